//--- list.f
verilog/mips_pkg.sv
verilog/ex_mem.sv
verilog/mem_access_fsm.sv
verilog/lane_align.sv
verilog/wb_data_ram.sv
verilog/mem_wb.sv
verilog/mem_stage_top.sv
tests/tb_mem_stage.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mem_stage
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_mem_stage.sv
module tb_mem_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW           = 6;                  // RAM word-address bits
  localparam int WS           = 2;                  // RAM wait states
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ISSUED   = 156;                // 3 + 64 + 2 + 24 + 3 + 60
  localparam mips_pkg::opcode_e OPS [11] = '{mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI,
    mips_pkg::OP_ORI, mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW, mips_pkg::OP_LBU,
    mips_pkg::OP_LHU, mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};

  logic                 clk;
  logic                 arst_n;
  logic                 flush;
  logic                 stall;
  mips_pkg::ex_mem_t    ex_in;
  mips_pkg::wb_result_t wb_out;
  mips_pkg::wb_result_t expected_q [$];             // Write-back results in issue order
  logic [31:0]          ref_mem [2**AW];            // Reference copy of the data RAM
  logic [31:0]          lfsr;
  string                test_name;
  int                   value_errors;
  int                   other_errors;

  mem_stage_top #(.ADDR_WIDTH(AW), .WAIT_STATES(WS)) mem_stage_top_inst (
    .clk(clk), .arst_n(arst_n), .flush(flush),
    .ex_in(ex_in), .stall(stall), .wb_out(wb_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};                  // One step per bit
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic mips_pkg::ex_mem_t make_instr(input mips_pkg::opcode_e op,
      input logic [31:0] alu, input logic [31:0] data, input logic [4:0] rd);
    mips_pkg::ex_mem_t ins;
    ins                = '0;
    ins.valid          = 1'b1;
    ins.alu_result     = alu;
    ins.store_data     = data;
    ins.opcode         = op;
    ins.mem_read       = op inside {mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
                                    mips_pkg::OP_LBU, mips_pkg::OP_LHU};
    ins.mem_write      = op inside {mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
    ins.mem_to_reg     = ins.mem_read;
    ins.reg_write      = !ins.mem_write;            // Stores write no register
    ins.write_register = ins.mem_write ? 5'd0 : rd;
    return ins;
  endfunction

  task automatic check_result(input mips_pkg::wb_result_t exp, input mips_pkg::wb_result_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected v=%b rw=%b rd=%0d data=%h, actual v=%b rw=%b rd=%0d data=%h",
               test_name, exp.valid, exp.reg_write, exp.write_register, exp.data,
               act.valid, act.reg_write, act.write_register, act.data);
    end
  endtask

  task automatic check_bit(input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %b actual %b", test_name, exp, act);
    end
  endtask

  // Memory model and expected result, byte lanes little-endian
  task automatic record(input mips_pkg::ex_mem_t ins);
    mips_pkg::wb_result_t exp;
    logic [AW-1:0]        idx;
    logic [31:0]          off;
    logic [31:0]          word;
    logic [7:0]           b;
    logic [15:0]          h;
    idx  = ins.alu_result[AW+1:2];
    off  = 32'(ins.alu_result[1:0]);
    word = ref_mem[idx];
    b    = 8'(word >> (8 * off));
    h    = 16'(word >> (8 * (off & 32'd2)));        // Address bit 0 ignored for halves
    exp.valid          = 1'b1;
    exp.reg_write      = ins.reg_write && (ins.write_register != '0);
    exp.write_register = ins.write_register;
    exp.data           = ins.alu_result;            // ALU ops and stores
    case (ins.opcode)
      mips_pkg::OP_SB:  ref_mem[idx][8*off +: 8] = ins.store_data[7:0];
      mips_pkg::OP_SH:  ref_mem[idx][8*(off & 32'd2) +: 16] = ins.store_data[15:0];
      mips_pkg::OP_SW:  ref_mem[idx] = ins.store_data;
      mips_pkg::OP_LB:  exp.data = {{24{b[7]}}, b};
      mips_pkg::OP_LBU: exp.data = {24'd0, b};
      mips_pkg::OP_LH:  exp.data = {{16{h[15]}}, h};
      mips_pkg::OP_LHU: exp.data = {16'd0, h};
      mips_pkg::OP_LW:  exp.data = word;
      default: ;
    endcase
    expected_q.push_back(exp);
  endtask

  // Hold the instruction until an edge with stall low takes it
  task automatic issue(input mips_pkg::ex_mem_t ins, input logic kill);
    logic taken;
    taken = 1'b0;
    ex_in = ins;
    flush = kill;
    while (!taken) begin
      @(negedge clk);
      taken = (stall == 1'b0);                      // Level seen by the coming edge
      @(posedge clk);
    end
    #1;
    ex_in = '0;                                     // Bubble until the next issue
    flush = 1'b0;
    if (!kill) record(ins);
  endtask

  task automatic issue_op(input mips_pkg::opcode_e op, input logic [31:0] alu);
    logic [31:0] data;
    logic [4:0]  rd;
    data = rand_bits(32);
    rd   = 5'(rand_bits(5));
    issue(make_instr(op, alu, data, rd), 1'b0);
  endtask

  task automatic check_stall_window();
    repeat (WS + 3) begin                           // Request, bus cycle, ack cycle
      @(negedge clk);
      check_bit(1'b1, stall);
    end
    @(negedge clk);
    check_bit(1'b0, stall);                         // DONE cycle lets the pipe move
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < 40) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expected_q.size() != 0) begin
      other_errors++;
      $display("%s: %0d results never came out on wb_out", test_name, expected_q.size());
      expected_q.delete();
    end
    repeat (4) @(posedge clk);                      // Room for a stray duplicate
    #1;
  endtask

  always @(negedge clk) begin
    if (arst_n && wb_out.valid !== 1'b0) begin
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("%s: wb_out gave a result that no instruction accounts for", test_name);
      end else begin
        check_result(expected_q.pop_front(), wb_out);
      end
    end
  end

  task automatic alu_passthrough();
    test_name = "alu_passthrough";
    @(negedge clk);
    check_bit(1'b0, stall);
    check_bit(1'b0, wb_out.valid);
    @(posedge clk);
    #1;
    issue_op(mips_pkg::OP_ADDI, rand_bits(32));
    issue_op(mips_pkg::OP_RTYPE, rand_bits(32));
    issue(make_instr(mips_pkg::OP_ADDI, rand_bits(32), '0, 5'd0), 1'b0);  // $zero target
    drain();
  endtask

  task automatic fill_memory();
    test_name = "fill_memory";
    for (int i = 0; i < 2**AW; i++) begin
      issue(make_instr(mips_pkg::OP_SW, i << 2, 32'h9e3779b9 * (i + 1), 5'd0), 1'b0);
    end
    drain();
  endtask

  task automatic word_store_load();
    logic [31:0] addr;
    test_name = "word_store_load";
    addr      = rand_bits(8);
    issue_op(mips_pkg::OP_SW, addr);
    check_stall_window();
    issue_op(mips_pkg::OP_LW, addr);
    check_stall_window();
    drain();
  endtask

  task automatic narrow_lanes();
    logic [31:0] base;
    test_name = "narrow_lanes";
    base      = rand_bits(AW) << 2;
    for (int off = 0; off < 4; off++) begin
      issue_op(mips_pkg::OP_SB, base + off);
      issue_op(mips_pkg::OP_LB, base + off);
      issue_op(mips_pkg::OP_LBU, base + off);
      issue_op(mips_pkg::OP_LW, base);             // Other bytes unchanged
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_op(mips_pkg::OP_SH, base + off);
      issue_op(mips_pkg::OP_LH, base + off);
      issue_op(mips_pkg::OP_LHU, base + off);
      issue_op(mips_pkg::OP_LW, base);
    end
    drain();
  endtask

  task automatic flush_kill();
    logic [31:0] addr;
    test_name = "flush_kill";
    addr      = rand_bits(8);
    issue(make_instr(mips_pkg::OP_ADDI, rand_bits(32), '0, 5'd3), 1'b1);
    issue(make_instr(mips_pkg::OP_SW, addr, ~ref_mem[addr[AW+1:2]], 5'd0), 1'b1);
    @(negedge clk);
    check_bit(1'b0, stall);                         // Dropped store starts no bus cycle
    @(posedge clk);
    #1;
    issue_op(mips_pkg::OP_LW, addr);               // Old word still there
    drain();
  endtask

  task automatic random_mix();
    mips_pkg::opcode_e op;
    logic [31:0]       alu;
    int                k;
    test_name = "random_mix";
    for (int n = 0; n < 60; n++) begin
      k   = rand_bits(4) % 11;
      op  = OPS[k];
      alu = (op inside {mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_ORI}) ?
            rand_bits(32) : rand_bits(8);
      issue_op(op, alu);
    end
    drain();
  endtask

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 40 * NUM_ISSUED));
    $display("Timeout in %s, the run went past its cycle budget", test_name);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    flush        = 1'b0;
    ex_in        = '0;
    lfsr         = 32'he829;
    value_errors = 0;
    other_errors = 0;
    test_name    = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    alu_passthrough();
    fill_memory();
    word_store_load();
    narrow_lanes();
    flush_kill();
    random_mix();
    $display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/mem_stage_top.sv
module mem_stage_top #(
  parameter int ADDR_WIDTH  = 8,
  parameter int WAIT_STATES = 1
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,
  input  mips_pkg::ex_mem_t    ex_in,
  output logic                 stall,
  output mips_pkg::wb_result_t wb_out
);

  mips_pkg::ex_mem_t               ex_q;
  mips_pkg::wb_req_t               wb_req;
  mips_pkg::wb_rsp_t               wb_rsp;
  logic [mips_pkg::DATA_WIDTH-1:0] store_lanes;
  logic [mips_pkg::SEL_WIDTH-1:0]  store_sel;
  logic [mips_pkg::DATA_WIDTH-1:0] read_word;
  logic [mips_pkg::DATA_WIDTH-1:0] load_data;
  logic                            mem_done;

  ex_mem ex_mem_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .stall  (stall),
    .ex_in  (ex_in),
    .ex_q   (ex_q)
  );

  mem_access_fsm mem_access_fsm_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .ex_q        (ex_q),
    .store_lanes (store_lanes),
    .store_sel   (store_sel),
    .wb_rsp      (wb_rsp),
    .wb_req      (wb_req),
    .read_word   (read_word),
    .stall       (stall),
    .mem_done    (mem_done)
  );

  lane_align lane_align_inst (
    .ex_q        (ex_q),
    .read_word   (read_word),
    .store_lanes (store_lanes),
    .store_sel   (store_sel),
    .load_data   (load_data)
  );

  wb_data_ram #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .WAIT_STATES (WAIT_STATES)
  ) wb_data_ram_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  mem_wb mem_wb_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .ex_q      (ex_q),
    .stall     (stall),
    .mem_done  (mem_done),
    .load_data (load_data),
    .wb_out    (wb_out)
  );

endmodule

//--- verilog/mem_wb.sv
module mem_wb (
  input  logic                              clk,
  input  logic                              arst_n,
  input  mips_pkg::ex_mem_t                 ex_q,
  input  logic                              stall,
  input  logic                              mem_done,  // Load data is valid
  input  logic [mips_pkg::DATA_WIDTH-1:0]   load_data,
  output mips_pkg::wb_result_t              wb_out
);

  logic                                valid_q;
  logic                                reg_write_q;
  logic [mips_pkg::REG_ADDR_WIDTH-1:0] write_register_q;
  logic [mips_pkg::DATA_WIDTH-1:0]     data_q;
  logic                                is_mem;
  logic                                take;         // Slot leaves MEM this edge

  assign is_mem = ex_q.mem_read || ex_q.mem_write;
  assign take   = !stall && ex_q.valid && (!is_mem || mem_done);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q     <= 1'b0;
      reg_write_q <= 1'b0;
    end else begin
      valid_q     <= take;                          // Bubble while stalled
      reg_write_q <= take && ex_q.reg_write && (ex_q.write_register != '0);  // $zero stays 0
    end
  end

  always_ff @(posedge clk) begin
    write_register_q <= ex_q.write_register;
    data_q           <= ex_q.mem_to_reg ? load_data : ex_q.alu_result;
  end

  always_comb begin
    wb_out.valid          = valid_q;
    wb_out.reg_write      = reg_write_q;
    wb_out.write_register = write_register_q;
    wb_out.data           = data_q;
  end

endmodule

//--- verilog/wb_data_ram.sv
module wb_data_ram #(
  parameter int ADDR_WIDTH  = 8,                    // Word address bits
  parameter int WAIT_STATES = 1                     // Extra cycles before ack
) (
  input  logic              clk,
  input  logic              arst_n,
  input  mips_pkg::wb_req_t wb_req,
  output mips_pkg::wb_rsp_t wb_rsp
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [mips_pkg::DATA_WIDTH-1:0] mem [DEPTH];
  logic [ADDR_WIDTH-1:0]           word_adr;        // Upper adr bits ignored
  logic [CNT_W-1:0]                wait_cnt;
  logic                            ack_q;
  logic                            hit;             // Last wait cycle, access now
  logic [mips_pkg::DATA_WIDTH-1:0] rdat;

  assign word_adr = wb_req.adr[ADDR_WIDTH-1:0];
  assign hit      = wb_req.cyc && wb_req.stb && !ack_q && (wait_cnt == CNT_W'(WAIT_STATES));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
      ack_q    <= 1'b0;
    end else if (ack_q) begin
      ack_q    <= 1'b0;                             // One-cycle ack, stb still up here
      wait_cnt <= '0;
    end else if (hit) begin
      ack_q    <= 1'b1;
      wait_cnt <= '0;
    end else if (wb_req.cyc && wb_req.stb) begin
      wait_cnt <= wait_cnt + 1'b1;                  // Count off wait states
    end
  end

  // Write and read both happen on the edge that raises ack
  always_ff @(posedge clk) begin
    if (hit) begin
      if (wb_req.we) begin
        for (int i = 0; i < mips_pkg::SEL_WIDTH; i++) begin
          if (wb_req.sel[i]) mem[word_adr][8*i +: 8] <= wb_req.dat[8*i +: 8];
        end
      end
      rdat <= mem[word_adr];                        // Old contents on a store
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat;

endmodule

//--- verilog/lane_align.sv
module lane_align (
  input  mips_pkg::ex_mem_t                 ex_q,
  input  logic [mips_pkg::DATA_WIDTH-1:0]   read_word,    // Raw word from RAM
  output logic [mips_pkg::DATA_WIDTH-1:0]   store_lanes,
  output logic [mips_pkg::SEL_WIDTH-1:0]    store_sel,
  output logic [mips_pkg::DATA_WIDTH-1:0]   load_data     // Extended load result
);

  logic [1:0]  offset;                              // Byte offset in the word
  logic [7:0]  byte_val;
  logic [15:0] half_val;

  assign offset = ex_q.alu_result[1:0];

  // Replicate narrow stores so every lane carries the value, sel picks the lane
  always_comb begin
    case (ex_q.opcode)
      mips_pkg::OP_SB, mips_pkg::OP_LB, mips_pkg::OP_LBU: begin
        store_lanes = {4{ex_q.store_data[7:0]}};
        store_sel   = 4'b0001 << offset;
      end
      mips_pkg::OP_SH, mips_pkg::OP_LH, mips_pkg::OP_LHU: begin
        store_lanes = {2{ex_q.store_data[15:0]}};
        store_sel   = offset[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
      end
      default: begin
        store_lanes = ex_q.store_data;              // Word access
        store_sel   = 4'b1111;
      end
    endcase
  end

  // Little-endian, lane 0 at byte offset 0
  always_comb begin
    case (offset)
      2'd0:    byte_val = read_word[7:0];
      2'd1:    byte_val = read_word[15:8];
      2'd2:    byte_val = read_word[23:16];
      default: byte_val = read_word[31:24];
    endcase
    half_val = offset[1] ? read_word[31:16] : read_word[15:0];
  end

  always_comb begin
    case (ex_q.opcode)
      mips_pkg::OP_LB:  load_data = {{24{byte_val[7]}}, byte_val};    // Sign extend
      mips_pkg::OP_LBU: load_data = {24'd0, byte_val};
      mips_pkg::OP_LH:  load_data = {{16{half_val[15]}}, half_val};
      mips_pkg::OP_LHU: load_data = {16'd0, half_val};
      default:          load_data = read_word;      // LW
    endcase
  end

endmodule

//--- verilog/mem_access_fsm.sv
module mem_access_fsm (
  input  logic                                clk,
  input  logic                                arst_n,
  input  mips_pkg::ex_mem_t                   ex_q,        // Instruction in MEM
  input  logic [mips_pkg::DATA_WIDTH-1:0]     store_lanes, // Lane-steered store data
  input  logic [mips_pkg::SEL_WIDTH-1:0]      store_sel,   // Byte enables
  input  mips_pkg::wb_rsp_t                   wb_rsp,
  output mips_pkg::wb_req_t                   wb_req,
  output logic [mips_pkg::DATA_WIDTH-1:0]     read_word,   // Word captured on ack
  output logic                                stall,
  output logic                                mem_done     // One cycle, access finished
);

  mips_pkg::mem_state_e state;
  mips_pkg::mem_state_e state_nxt;
  logic                 mem_req;                    // Current slot needs the bus

  assign mem_req = ex_q.valid && (ex_q.mem_read || ex_q.mem_write);

  always_comb begin
    state_nxt = state;
    case (state)
      mips_pkg::ST_IDLE: if (mem_req) state_nxt = mips_pkg::ST_BUS;
      mips_pkg::ST_BUS:  if (wb_rsp.ack) state_nxt = mips_pkg::ST_DONE;
      mips_pkg::ST_DONE: state_nxt = mips_pkg::ST_IDLE;  // ex_q advances here
      default:           state_nxt = mips_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= mips_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Read word held for lane_align during ST_DONE
  always_ff @(posedge clk) begin
    if (state == mips_pkg::ST_BUS && wb_rsp.ack) begin
      read_word <= wb_rsp.dat;
    end
  end

  // Stall goes up at once in IDLE so ex_mem never moves past a pending access
  assign stall    = (state == mips_pkg::ST_IDLE && mem_req) || (state == mips_pkg::ST_BUS);
  assign mem_done = (state == mips_pkg::ST_DONE);

  always_comb begin
    wb_req.cyc = (state == mips_pkg::ST_BUS);       // Dropped the cycle after ack
    wb_req.stb = (state == mips_pkg::ST_BUS);
    wb_req.we  = ex_q.mem_write;                    // Stable, ex_q held under stall
    wb_req.adr = ex_q.alu_result[mips_pkg::DATA_WIDTH-1:2];
    wb_req.dat = store_lanes;
    wb_req.sel = store_sel;
  end

endmodule

//--- verilog/ex_mem.sv
module ex_mem (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,                  // Kill the instruction entering MEM
  input  logic              stall,                  // Memory access still pending
  input  mips_pkg::ex_mem_t ex_in,                  // From execute stage
  output mips_pkg::ex_mem_t ex_q                    // To memory stage
);

  localparam mips_pkg::ex_mem_t BUBBLE = '{         // Empty slot, no side effects
    valid:          1'b0,
    alu_result:     '0,
    store_data:     '0,
    write_register: '0,
    reg_write:      1'b0,
    mem_read:       1'b0,
    mem_write:      1'b0,
    mem_to_reg:     1'b0,
    opcode:         mips_pkg::OP_RTYPE
  };

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_q <= BUBBLE;
    end else if (!stall) begin                      // Hold while the bus is busy
      if (flush) begin
        ex_q <= BUBBLE;                             // Drop it before any bus cycle
      end else begin
        ex_q <= ex_in;
      end
    end
  end

endmodule

//--- verilog/mips_pkg.sv
package mips_pkg;

  localparam int DATA_WIDTH     = 32;               // Data word width
  localparam int REG_ADDR_WIDTH = 5;                // Register index width
  localparam int OPCODE_WIDTH   = 6;                // MIPS primary opcode field
  localparam int SEL_WIDTH      = DATA_WIDTH / 8;   // One select per byte lane
  localparam int WB_ADR_WIDTH   = DATA_WIDTH - 2;   // Full word address on the bus

  // Primary opcodes at their MIPS encodings
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_ORI   = 6'h0d,
    OP_LB    = 6'h20,
    OP_LH    = 6'h21,
    OP_LW    = 6'h23,
    OP_LBU   = 6'h24,
    OP_LHU   = 6'h25,
    OP_SB    = 6'h28,
    OP_SH    = 6'h29,
    OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,                                 // No bus cycle
    ST_BUS  = 2'd1,                                 // cyc/stb up, waiting for ack
    ST_DONE = 2'd2                                  // Result ready, pipe advances
  } mem_state_e;

  typedef struct packed {
    logic                      valid;               // Slot holds an instruction
    logic [DATA_WIDTH-1:0]     alu_result;          // Also the byte address for ld/st
    logic [DATA_WIDTH-1:0]     store_data;          // rt value
    logic [REG_ADDR_WIDTH-1:0] write_register;      // Destination register
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      mem_to_reg;          // WB takes load data
    opcode_e                   opcode;
  } ex_mem_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [WB_ADR_WIDTH-1:0] adr;                   // Word address
    logic [DATA_WIDTH-1:0]   dat;                   // Lane-steered write data
    logic [SEL_WIDTH-1:0]    sel;                   // Byte enables
  } wb_req_t;

  typedef struct packed {
    logic                  ack;                     // Single-cycle acknowledge
    logic [DATA_WIDTH-1:0] dat;                     // Read word, valid with ack
  } wb_rsp_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic [REG_ADDR_WIDTH-1:0] write_register;
    logic [DATA_WIDTH-1:0]     data;                // Value for the register file
  } wb_result_t;

endpackage
